//--- bench/stride_stimulus.txt
# One command per line, all hex
# pid raddr laddr dwidth stride nbytes
000001 000000010000 000000200000 0 00000001 0000000d
000002 000000020040 000000300010 2 00001000 00000028
000003 000000030000 000000400000 3 00000008 00000040
000004 000000040008 000000500003 1 00000006 00000016
000005 000000050000 0000006000f0 3 00000100 00000018
000006 000000060000 000000700001 0 00000003 00000001
000007 000000070000 000000800ff8 2 00000004 00000020
000008 000000080010 000000912345 1 00000002 0000000a
000009 000000090000 000000a00000 3 00010000 00000010
00000a 0000000a0000 000000b0007c 2 00000014 0000000c

//--- sources.f
hw/stride_pkg.sv
hw/stride_req.sv
hw/stride_packer.sv
hw/stride_top.sv
bench/stride_checker.sv
bench/tb_stride_top.sv

//--- bench/tb_stride_top.sv
`timescale 1ns/10ps

module tb_stride_top;
    import stride_pkg::*;

    localparam int data_bits  = 64;
    localparam int max_cmds   = 32;
    localparam int wait_limit = 5000;

    logic                   aclk = 1'b0;
    logic                   aresetn;
    logic                   cmd_valid, cmd_ready;
    logic [pid_bits-1:0]    cmd_pid;
    logic [vaddr_bits-1:0]  cmd_raddr, cmd_laddr;
    logic [dwidth_bits-1:0] cmd_dwidth;
    logic [len_bits-1:0]    cmd_stride, cmd_nbytes;
    logic                   wr_cmd_valid, wr_cmd_ready;
    app_op_t                wr_cmd_op;
    logic [pid_bits-1:0]    wr_cmd_pid;
    logic [vaddr_bits-1:0]  wr_cmd_raddr;
    logic [len_bits-1:0]    wr_cmd_len;
    logic                   rd_req_valid, rd_req_ready, rd_req_last;
    logic [vaddr_bits-1:0]  rd_req_vaddr;
    logic [len_bits-1:0]    rd_req_len;
    logic                   rd_data_valid, rd_data_ready;
    logic [data_bits-1:0]   rd_data;
    logic                   wr_data_valid, wr_data_ready, wr_data_last;
    logic [data_bits-1:0]   wr_data;
    logic [data_bits/8-1:0] wr_data_keep;

    logic [31:0]            rng = 32'd5371;
    logic                   report;
    int                     err_count, done_count, n_cmds;
    bit                     hung;

    // Commands from the stimulus file
    logic [pid_bits-1:0]    s_pid[max_cmds];
    logic [vaddr_bits-1:0]  s_raddr[max_cmds], s_laddr[max_cmds];
    logic [dwidth_bits-1:0] s_dwidth[max_cmds];
    logic [len_bits-1:0]    s_stride[max_cmds], s_nbytes[max_cmds];

    // Outstanding host reads answered in order
    logic [vaddr_bits-1:0]  hq_addr[$];
    logic [len_bits-1:0]    hq_len[$];

    always #2 aclk = ~aclk;

    stride_top #(.str_data_bits(data_bits)) dut_i (.*);

    stride_checker #(.str_data_bits(data_bits)) chk_i (.*);

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    // High about three times in four
    function automatic logic chance_high();
        logic [31:0] r;
        r = lcg_next();
        return r[17:16] != 2'b00;
    endfunction

    function automatic logic [data_bits-1:0] host_element(input logic [vaddr_bits-1:0] addr,
                                                          input logic [len_bits-1:0] len);
        logic [data_bits-1:0]  d;
        logic [vaddr_bits-1:0] a;
        d = '0;
        for (int j = 0; j < data_bits / 8; j++) begin
            a = addr + vaddr_bits'(j);
            if (j < len) begin
                d[8*j +: 8] = a[7:0] ^ a[15:8];
            end
        end
        return d;
    endfunction

    always @(posedge aclk) begin
        if (rd_req_valid && rd_req_ready) begin
            hq_addr.push_back(rd_req_vaddr);
            hq_len.push_back(rd_req_len);
        end
        if (rd_data_valid && rd_data_ready) begin
            void'(hq_addr.pop_front());
            void'(hq_len.pop_front());
        end
    end

    // Random back-pressure and host responses
    always @(negedge aclk) begin
        if (aresetn) begin
            wr_cmd_ready  = chance_high();
            rd_req_ready  = chance_high();
            wr_data_ready = chance_high();
            if (hq_addr.size() > 0 && chance_high()) begin
                rd_data_valid = 1'b1;
                rd_data       = host_element(hq_addr[0], hq_len[0]);
            end else begin
                rd_data_valid = 1'b0;
                rd_data       = '0;
            end
        end
    end

    task automatic send_command(input int i);
        int waited;
        waited     = 0;
        cmd_valid  = 1'b1;
        cmd_pid    = s_pid[i];
        cmd_raddr  = s_raddr[i];
        cmd_laddr  = s_laddr[i];
        cmd_dwidth = s_dwidth[i];
        cmd_stride = s_stride[i];
        cmd_nbytes = s_nbytes[i];
        @(posedge aclk);
        while (!cmd_ready && waited < wait_limit) begin
            waited++;
            @(posedge aclk);
        end
        if (waited >= wait_limit) begin
            $display("Command %0d was never accepted by the DUT", i);
            hung = 1'b1;
        end
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_all_done();
        int waited;
        waited = 0;
        while (done_count < n_cmds && waited < wait_limit * 4) begin
            waited++;
            @(negedge aclk);
        end
        if (done_count < n_cmds) begin
            $display("Write data stopped after %0d of %0d commands", done_count, n_cmds);
            hung = 1'b1;
        end
    endtask

    initial begin
        int    fd;
        int    code;
        string line;
        aresetn       = 1'b0;
        cmd_valid     = 1'b0;
        cmd_pid       = '0;
        cmd_raddr     = '0;
        cmd_laddr     = '0;
        cmd_dwidth    = '0;
        cmd_stride    = '0;
        cmd_nbytes    = '0;
        wr_cmd_ready  = 1'b0;
        rd_req_ready  = 1'b0;
        rd_data_valid = 1'b0;
        rd_data       = '0;
        wr_data_ready = 1'b0;
        report        = 1'b0;
        hung          = 1'b0;
        n_cmds        = 0;

        fd = $fopen("bench/stride_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            hung = 1'b1;
        end else begin
            while (!$feof(fd) && n_cmds < max_cmds) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h %h %h %h %h", s_pid[n_cmds], s_raddr[n_cmds],
                                s_laddr[n_cmds], s_dwidth[n_cmds], s_stride[n_cmds],
                                s_nbytes[n_cmds]) == 6) begin
                        n_cmds++;
                    end
                end
            end
            $fclose(fd);
        end

        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        // Idle window where outputs must stay low
        repeat (4) @(negedge aclk);

        for (int i = 0; i < n_cmds && !hung; i++) begin
            send_command(i);
        end
        if (!hung) begin
            wait_all_done();
        end

        @(negedge aclk);
        report = 1'b1;
        #1;
        if (hung || n_cmds == 0 || err_count != 0 || done_count != n_cmds) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

//--- bench/stride_checker.sv
`timescale 1ns/10ps

module stride_checker #(
    parameter int str_data_bits = 64
) (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               cmd_valid,
    input  logic                               cmd_ready,
    input  logic [stride_pkg::pid_bits-1:0]    cmd_pid,
    input  logic [stride_pkg::vaddr_bits-1:0]  cmd_raddr,
    input  logic [stride_pkg::vaddr_bits-1:0]  cmd_laddr,
    input  logic [stride_pkg::dwidth_bits-1:0] cmd_dwidth,
    input  logic [stride_pkg::len_bits-1:0]    cmd_stride,
    input  logic [stride_pkg::len_bits-1:0]    cmd_nbytes,
    input  logic                               wr_cmd_valid,
    input  logic                               wr_cmd_ready,
    input  stride_pkg::app_op_t                wr_cmd_op,
    input  logic [stride_pkg::pid_bits-1:0]    wr_cmd_pid,
    input  logic [stride_pkg::vaddr_bits-1:0]  wr_cmd_raddr,
    input  logic [stride_pkg::len_bits-1:0]    wr_cmd_len,
    input  logic                               rd_req_valid,
    input  logic                               rd_req_ready,
    input  logic [stride_pkg::vaddr_bits-1:0]  rd_req_vaddr,
    input  logic [stride_pkg::len_bits-1:0]    rd_req_len,
    input  logic                               rd_req_last,
    input  logic                               rd_data_ready,
    input  logic                               wr_data_valid,
    input  logic                               wr_data_ready,
    input  logic [str_data_bits-1:0]           wr_data,
    input  logic [str_data_bits/8-1:0]         wr_data_keep,
    input  logic                               wr_data_last,
    input  logic                               report,
    output int                                 err_count,
    output int                                 done_count
);
    import stride_pkg::*;

    localparam int beat_bytes = str_data_bits / 8;

    logic [vaddr_bits-1:0]  c_raddr, c_laddr;
    logic [pid_bits-1:0]    c_pid;
    logic [dwidth_bits-1:0] c_dwidth;
    logic [len_bits-1:0]    c_stride, c_nbytes;
    logic [str_data_bits-1:0] exp_data, data_mask;
    logic [beat_bytes-1:0]  exp_keep;
    longint n_elem, n_beats;
    int     n_req, n_beat, n_wcmd, t_err;
    bit     started;

    initial begin
        err_count  = 0;
        done_count = 0;
        started    = 1'b0;
    end

    function automatic logic [7:0] host_byte(input logic [vaddr_bits-1:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    // Byte s of the stream is byte s mod size of element s / size
    task automatic build_beat(input int k);
        longint s;
        logic [vaddr_bits-1:0] a;
        exp_data  = '0;
        data_mask = '0;
        exp_keep  = '0;
        for (int b = 0; b < beat_bytes; b++) begin
            s = longint'(k) * beat_bytes + b;
            if (s < c_nbytes) begin
                a = c_laddr + vaddr_bits'((s >> c_dwidth) * c_stride)
                    + vaddr_bits'(s & ((longint'(1) << c_dwidth) - 1));
                exp_data[8*b +: 8]  = host_byte(a);
                data_mask[8*b +: 8] = 8'hff;
                exp_keep[b]         = 1'b1;
            end
        end
    endtask

    task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] cmd%0d %s expected %h actual %h", done_count, what, exp, act);
        t_err++;
        err_count++;
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            if (!started && !cmd_valid && (cmd_ready || wr_cmd_valid || rd_req_valid
                                           || rd_data_ready || wr_data_valid)) begin
                $display("A control output went high before any command arrived");
                err_count++;
            end
            if (cmd_valid && cmd_ready) begin
                started  = 1'b1;
                c_pid    = cmd_pid;
                c_raddr  = cmd_raddr;
                c_laddr  = cmd_laddr;
                c_dwidth = cmd_dwidth;
                c_stride = cmd_stride;
                c_nbytes = cmd_nbytes;
                n_elem   = cmd_nbytes >> cmd_dwidth;
                n_beats  = (longint'(cmd_nbytes) + beat_bytes - 1) / beat_bytes;
                n_req    = 0;
                n_beat   = 0;
                n_wcmd   = 0;
                t_err    = 0;
            end
            if (wr_cmd_valid && wr_cmd_ready) begin
                n_wcmd++;
                if (wr_cmd_op !== app_write) mismatch("op", app_write, wr_cmd_op);
                if (wr_cmd_pid !== c_pid) mismatch("pid", c_pid, wr_cmd_pid);
                if (wr_cmd_raddr !== c_raddr) mismatch("raddr", c_raddr, wr_cmd_raddr);
                if (wr_cmd_len !== c_nbytes) mismatch("len", c_nbytes, wr_cmd_len);
            end
            if (rd_req_valid && rd_req_ready) begin
                if (n_req >= n_elem) begin
                    $display("cmd%0d issued more read requests than elements", done_count);
                    t_err++;
                    err_count++;
                end else begin
                    if (rd_req_vaddr !== c_laddr + vaddr_bits'(longint'(n_req) * c_stride))
                        mismatch("req addr", c_laddr + vaddr_bits'(longint'(n_req) * c_stride),
                                 rd_req_vaddr);
                    if (rd_req_len !== (len_bits'(1) << c_dwidth))
                        mismatch("req len", len_bits'(1) << c_dwidth, rd_req_len);
                    if (rd_req_last !== (n_req == n_elem - 1))
                        mismatch("req last", n_req == n_elem - 1, rd_req_last);
                end
                n_req++;
            end
            if (wr_data_valid && wr_data_ready) begin
                build_beat(n_beat);
                if (wr_data_keep !== exp_keep) mismatch("keep", exp_keep, wr_data_keep);
                if ((wr_data & data_mask) !== exp_data)
                    mismatch($sformatf("beat%0d data", n_beat), exp_data, wr_data & data_mask);
                if (wr_data_last !== (n_beat == n_beats - 1))
                    mismatch("beat last", n_beat == n_beats - 1, wr_data_last);
                n_beat++;
                if (wr_data_last) begin
                    if (n_req != n_elem) mismatch("request count", n_elem, n_req);
                    if (n_beat != n_beats) mismatch("beat count", n_beats, n_beat);
                    if (n_wcmd != 1) mismatch("write commands", 1, n_wcmd);
                    $display("cmd%0d done: %0d requests, %0d beats, %0d errors",
                             done_count, n_req, n_beat, t_err);
                    done_count++;
                end
            end
        end
    end

    always @(posedge report) begin
        $display("Summary: %0d commands checked, %0d errors", done_count, err_count);
    end

endmodule

//--- hw/stride_top.sv
`timescale 1ns/10ps

module stride_top #(
    parameter int str_data_bits = 64
) (
    input  logic                              aclk,
    input  logic                              aresetn,

    // Network command in
    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  logic [stride_pkg::pid_bits-1:0]    cmd_pid,
    input  logic [stride_pkg::vaddr_bits-1:0]  cmd_raddr,
    input  logic [stride_pkg::vaddr_bits-1:0]  cmd_laddr,
    input  logic [stride_pkg::dwidth_bits-1:0] cmd_dwidth,
    input  logic [stride_pkg::len_bits-1:0]    cmd_stride,
    input  logic [stride_pkg::len_bits-1:0]    cmd_nbytes,

    // Write command out
    output logic                              wr_cmd_valid,
    input  logic                              wr_cmd_ready,
    output stride_pkg::app_op_t               wr_cmd_op,
    output logic [stride_pkg::pid_bits-1:0]    wr_cmd_pid,
    output logic [stride_pkg::vaddr_bits-1:0]  wr_cmd_raddr,
    output logic [stride_pkg::len_bits-1:0]    wr_cmd_len,

    // Host read requests
    output logic                              rd_req_valid,
    input  logic                              rd_req_ready,
    output logic [stride_pkg::vaddr_bits-1:0]  rd_req_vaddr,
    output logic [stride_pkg::len_bits-1:0]    rd_req_len,
    output logic                              rd_req_last,

    // Host read data
    input  logic                              rd_data_valid,
    output logic                              rd_data_ready,
    input  logic [str_data_bits-1:0]          rd_data,

    // Packed write data
    output logic                              wr_data_valid,
    input  logic                              wr_data_ready,
    output logic [str_data_bits-1:0]          wr_data,
    output logic [str_data_bits/8-1:0]        wr_data_keep,
    output logic                              wr_data_last
);
    import stride_pkg::*;

    // Splitter to packer parameter channel
    logic                   par_valid;
    logic                   par_ready;
    logic [len_bits-1:0]    par_ntr;
    logic [dwidth_bits-1:0] par_dwidth;

    stride_req #(
        .str_data_bits (str_data_bits)
    ) req_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_pid       (cmd_pid),
        .cmd_raddr     (cmd_raddr),
        .cmd_laddr     (cmd_laddr),
        .cmd_dwidth    (cmd_dwidth),
        .cmd_stride    (cmd_stride),
        .cmd_nbytes    (cmd_nbytes),
        .wr_cmd_valid  (wr_cmd_valid),
        .wr_cmd_ready  (wr_cmd_ready),
        .wr_cmd_op     (wr_cmd_op),
        .wr_cmd_pid    (wr_cmd_pid),
        .wr_cmd_raddr  (wr_cmd_raddr),
        .wr_cmd_len    (wr_cmd_len),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_req_vaddr  (rd_req_vaddr),
        .rd_req_len    (rd_req_len),
        .rd_req_last   (rd_req_last),
        .par_valid     (par_valid),
        .par_ready     (par_ready),
        .par_ntr       (par_ntr),
        .par_dwidth    (par_dwidth)
    );

    stride_packer #(
        .str_data_bits (str_data_bits)
    ) pack_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .par_valid     (par_valid),
        .par_ready     (par_ready),
        .par_ntr       (par_ntr),
        .par_dwidth    (par_dwidth),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .rd_data       (rd_data),
        .wr_data_valid (wr_data_valid),
        .wr_data_ready (wr_data_ready),
        .wr_data       (wr_data),
        .wr_data_keep  (wr_data_keep),
        .wr_data_last  (wr_data_last)
    );

endmodule

//--- hw/stride_packer.sv
`timescale 1ns/10ps

module stride_packer #(
    parameter int str_data_bits = 64
) (
    input  logic                              aclk,
    input  logic                              aresetn,

    // Transfer parameters from the splitter
    input  logic                              par_valid,
    output logic                              par_ready,
    input  logic [stride_pkg::len_bits-1:0]    par_ntr,
    input  logic [stride_pkg::dwidth_bits-1:0] par_dwidth,

    // Elements returned by the host
    input  logic                              rd_data_valid,
    output logic                              rd_data_ready,
    input  logic [str_data_bits-1:0]          rd_data,

    // Packed beats toward the network
    output logic                              wr_data_valid,
    input  logic                              wr_data_ready,
    output logic [str_data_bits-1:0]          wr_data,
    output logic [str_data_bits/8-1:0]        wr_data_keep,
    output logic                              wr_data_last
);
    import stride_pkg::*;

    localparam int beat_bytes = str_data_bits / 8;
    localparam int beat_log   = $clog2(beat_bytes);

    pack_state_t state_q;

    // Transfer state
    logic [len_bits-1:0]      ntr_q;
    logic [dwidth_bits-1:0]   dwidth_q;
    logic [beat_log:0]        offset_q;
    logic [str_data_bits-1:0] acc_data_q;
    logic [beat_bytes-1:0]    acc_keep_q;

    // Output beat register
    logic                     out_valid_q;
    logic                     out_last_q;
    logic [str_data_bits-1:0] out_data_q;
    logic [beat_bytes-1:0]    out_keep_q;

    logic [beat_log:0]        elem_bytes;
    logic [beat_log:0]        offset_next;
    logic [beat_bytes:0]      elem_keep_wide;
    logic [beat_bytes-1:0]    elem_keep;
    logic [str_data_bits-1:0] elem_mask;
    logic [str_data_bits-1:0] merged_data;
    logic [beat_bytes-1:0]    merged_keep;

    logic par_take;
    logic elem_take;
    logic elem_last;
    logic beat_full;
    logic beat_emit;
    logic out_take;

    assign par_ready = (state_q == pk_idle);
    assign par_take  = par_valid && par_ready;

    // Stall input while a finished beat still waits
    assign rd_data_ready = (state_q == pk_run) && (ntr_q != '0)
                           && (!out_valid_q || wr_data_ready);

    assign elem_take = rd_data_valid && rd_data_ready;
    assign out_take  = out_valid_q && wr_data_ready;

    assign elem_bytes     = (beat_log + 1)'(1) << dwidth_q;
    assign elem_keep_wide = ((beat_bytes + 1)'(1) << elem_bytes) - 1'b1;
    assign elem_keep      = elem_keep_wide[beat_bytes-1:0];

    always_comb begin
        for (int i = 0; i < beat_bytes; i++) begin
            elem_mask[8*i +: 8] = {8{elem_keep[i]}};
        end
    end

    // Drop the element into the beat at the current byte offset
    assign merged_data = acc_data_q | ((rd_data & elem_mask) << {offset_q, 3'b000});
    assign merged_keep = acc_keep_q | (elem_keep << offset_q);

    assign offset_next = offset_q + elem_bytes;
    assign beat_full   = (offset_next == (beat_log + 1)'(beat_bytes));
    assign elem_last   = (ntr_q == len_bits'(1));
    assign beat_emit   = elem_take && (beat_full || elem_last);

    assign wr_data_valid = out_valid_q;
    assign wr_data       = out_data_q;
    assign wr_data_keep  = out_keep_q;
    assign wr_data_last  = out_last_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q     <= pk_idle;
            out_valid_q <= 1'b0;
        end else begin
            case (state_q)
                pk_idle: begin
                    if (par_take) begin
                        state_q <= pk_run;
                    end
                end
                pk_run: begin
                    // Done once the closing beat leaves
                    if (out_take && out_last_q) begin
                        state_q <= pk_idle;
                    end
                end
                default: state_q <= pk_idle;
            endcase

            if (beat_emit) begin
                out_valid_q <= 1'b1;
            end else if (out_take) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (par_take) begin
            ntr_q      <= par_ntr;
            dwidth_q   <= par_dwidth;
            offset_q   <= '0;
            acc_data_q <= '0;
            acc_keep_q <= '0;
        end else if (elem_take) begin
            ntr_q <= ntr_q - 1'b1;
            if (beat_emit) begin
                out_data_q <= merged_data;
                out_keep_q <= merged_keep;
                out_last_q <= elem_last;
                offset_q   <= '0;
                acc_data_q <= '0;
                acc_keep_q <= '0;
            end else begin
                offset_q   <= offset_next;
                acc_data_q <= merged_data;
                acc_keep_q <= merged_keep;
            end
        end
    end

    // Every emitted beat carries at least one element
    assert property (@(posedge aclk) disable iff (!aresetn)
        wr_data_valid |-> wr_data_keep != '0)
        else $error("stride_packer: beat with empty keep");

endmodule

//--- hw/stride_req.sv
`timescale 1ns/10ps

module stride_req #(
    parameter int str_data_bits = 64
) (
    input  logic                              aclk,
    input  logic                              aresetn,

    // Network command in
    input  logic                              cmd_valid,
    output logic                              cmd_ready,
    input  logic [stride_pkg::pid_bits-1:0]    cmd_pid,
    input  logic [stride_pkg::vaddr_bits-1:0]  cmd_raddr,
    input  logic [stride_pkg::vaddr_bits-1:0]  cmd_laddr,
    input  logic [stride_pkg::dwidth_bits-1:0] cmd_dwidth,
    input  logic [stride_pkg::len_bits-1:0]    cmd_stride,
    input  logic [stride_pkg::len_bits-1:0]    cmd_nbytes,

    // Write command out
    output logic                              wr_cmd_valid,
    input  logic                              wr_cmd_ready,
    output stride_pkg::app_op_t               wr_cmd_op,
    output logic [stride_pkg::pid_bits-1:0]    wr_cmd_pid,
    output logic [stride_pkg::vaddr_bits-1:0]  wr_cmd_raddr,
    output logic [stride_pkg::len_bits-1:0]    wr_cmd_len,

    // Host read requests
    output logic                              rd_req_valid,
    input  logic                              rd_req_ready,
    output logic [stride_pkg::vaddr_bits-1:0]  rd_req_vaddr,
    output logic [stride_pkg::len_bits-1:0]    rd_req_len,
    output logic                              rd_req_last,

    // Transfer parameters to the packer
    output logic                              par_valid,
    input  logic                              par_ready,
    output logic [stride_pkg::len_bits-1:0]    par_ntr,
    output logic [stride_pkg::dwidth_bits-1:0] par_dwidth
);
    import stride_pkg::*;

    localparam int beat_log = $clog2(str_data_bits / 8);

    str_state_t state_q, state_d;

    logic [len_bits-1:0]    cnt_q, cnt_d;
    logic [vaddr_bits-1:0]  laddr_q, laddr_d;
    logic [len_bits-1:0]    stride_q, stride_d;
    logic [dwidth_bits-1:0] dwidth_q, dwidth_d;
    logic                   last_q, last_d;

    logic                   accept;
    logic [len_bits-1:0]    cmd_ntr;

    // Number of elements in the command
    assign cmd_ntr = cmd_nbytes >> cmd_dwidth;

    // All three channels move on the same edge
    assign accept = (state_q == st_idle) && cmd_valid && wr_cmd_ready && par_ready;

    assign cmd_ready    = accept;
    assign wr_cmd_valid = accept;
    assign par_valid    = accept;

    assign wr_cmd_op    = app_write;
    assign wr_cmd_pid   = cmd_pid;
    assign wr_cmd_raddr = cmd_raddr;
    assign wr_cmd_len   = cmd_nbytes;

    assign par_ntr    = cmd_ntr;
    assign par_dwidth = cmd_dwidth;

    assign rd_req_vaddr = laddr_q;
    assign rd_req_len   = len_bits'(1) << dwidth_q;
    assign rd_req_last  = last_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge aclk) begin
        cnt_q    <= cnt_d;
        laddr_q  <= laddr_d;
        stride_q <= stride_d;
        dwidth_q <= dwidth_d;
        last_q   <= last_d;
    end

    always_comb begin
        state_d      = state_q;
        cnt_d        = cnt_q;
        laddr_d      = laddr_q;
        stride_d     = stride_q;
        dwidth_d     = dwidth_q;
        last_d       = last_q;
        rd_req_valid = 1'b0;

        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d  = st_read;
                    cnt_d    = cmd_ntr - 1'b1;
                    laddr_d  = cmd_laddr;
                    stride_d = cmd_stride;
                    dwidth_d = cmd_dwidth;
                    last_d   = (cmd_ntr == len_bits'(1));
                end
            end

            st_read: begin
                // Request goes out only when the host can take it
                if (rd_req_ready) begin
                    rd_req_valid = 1'b1;
                    cnt_d        = cnt_q - 1'b1;
                    laddr_d      = laddr_q + vaddr_bits'(stride_q);
                    last_d       = (cnt_q == len_bits'(1));
                    if (last_q) begin
                        state_d = st_idle;
                    end
                end
            end

            default: state_d = st_idle;
        endcase
    end

    // Zero elements would wrap the counter and never finish
    assert property (@(posedge aclk) disable iff (!aresetn)
        accept |-> cmd_ntr != '0)
        else $error("stride_req: command accepted with zero elements");

    // Packer cannot split an element across beats
    assert property (@(posedge aclk) disable iff (!aresetn)
        accept |-> cmd_dwidth <= dwidth_bits'(beat_log))
        else $error("stride_req: element wider than a beat");

endmodule

//--- hw/stride_pkg.sv
package stride_pkg;

    // Virtual address width for local and remote addresses
    localparam int vaddr_bits = 48;

    // Process id carried with every command
    localparam int pid_bits = 24;

    // Byte counts, strides and request lengths
    localparam int len_bits = 32;

    // Log2 of the element size in bytes
    localparam int dwidth_bits = 5;

    // Application opcodes toward the network stack
    typedef enum logic [4:0] {
        app_read  = 5'd0,
        app_write = 5'd1
    } app_op_t;

    // Command splitter FSM
    typedef enum logic [0:0] {
        st_idle,
        st_read
    } str_state_t;

    // Beat packer FSM
    typedef enum logic [0:0] {
        pk_idle,
        pk_run
    } pack_state_t;

endpackage
